/* scanFb.f */
design/scanFbPkg.sv
design/lineReadIf.sv
design/fetchSequencer.sv
design/lineBuffer.sv
design/pixelOutput.sv
design/scanFbTop.sv
verif/scanFbMemModel.sv
verif/scanFbTb.sv

/* Makefile */
TOP = scanFbTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f scanFb.f

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f scanFb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* verif/scanFbTb.sv */
`default_nettype none

module scanFbTb;
    timeunit 1ns;
    timeprecision 1ps;
    import scanFbPkg::*;

    logic clk;
    logic resetn;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic blank;
    logic flip;
    logic slow;
    logic memAck;
    logic rdValid;
    logic [3:0] rdId;
    logic [31:0] rdData;
    logic memReq;
    logic [31:0] memAddr;
    logic [7:0] memCount;
    logic [3:0] memId;
    rgb8_t color;
    logic [31:0] setAddr0;
    logic [31:0] setAddr1;
    int modelFaults;

    // Context of the driven position and of the sampled one
    logic [1:0] checkMode;
    logic blockFlip;
    logic lastVisFlip;
    logic [COORD_W-1:0] sampX;
    logic [COORD_W-1:0] sampY;
    logic sampBlank;
    logic sampFlip;
    logic sampBlockFlip;
    logic [1:0] sampMode;
    logic prevReq;
    logic prevAck;
    int errors;
    int underruns;
    int requests;

    scanFbTop dut_i (
        .clk(clk), .resetn(resetn), .x(x), .y(y), .blank(blank), .flip(flip),
        .memAck(memAck), .rdValid(rdValid), .rdId(rdId), .rdData(rdData),
        .memReq(memReq), .memAddr(memAddr), .memCount(memCount), .memId(memId),
        .color(color)
    );

    scanFbMemModel mem_i (
        .clk(clk), .resetn(resetn), .memReq(memReq), .memAddr(memAddr), .slow(slow),
        .memAck(memAck), .rdValid(rdValid), .rdId(rdId), .rdData(rdData),
        .setAddr0(setAddr0), .setAddr1(setAddr1), .faults(modelFaults)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] hashWord(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ (addr >> 3) ^ 32'h5a5a_1234;
    endfunction

    function automatic rgb8_t colorOf(input logic [31:0] word);
        return '{r: word[31:24], g: word[23:16], b: word[15:8]};
    endfunction

    function automatic rgb8_t expectedColor(input int px, input int py, input logic b1);
        return colorOf(hashWord((b1 ? FB_BASE1 : FB_BASE0) + 32'(((py / 2) * 16 + px / 2) * 4)));
    endfunction

    // Block start plus 8 words with row and frame wrap
    function automatic logic [31:0] nextBlockAddr(input int px, input int py, input logic b1);
        int nx;
        int ny;
        nx = ((px / 2) / 8) * 8 + 8;
        ny = py / 2;
        if (nx >= 16) begin
            nx = 0;
            if (py % 2 == 1) ny = (ny + 1) % 4;
        end
        return (b1 ? FB_BASE1 : FB_BASE0) + 32'((ny * 16 + nx) * 4);
    endfunction

    // Colour of the block last delivered into the shown set
    function automatic rgb8_t deliveredColor(input int px, input int py);
        int off;
        off = (py / 2) * 16 + px / 2;
        return colorOf(hashWord((((off / 8) % 2) ? setAddr1 : setAddr0) + 32'((off % 8) * 4)));
    endfunction

    ////////////////////////////////////////////////////////////
    // Comparing process
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        sampX = x;
        sampY = y;
        sampBlank = blank;
        sampFlip = flip;
        sampBlockFlip = blockFlip;
        sampMode = checkMode;
    end

    task automatic checkColor();
        rgb8_t exp;
        exp = '0;
        if (!sampBlank && sampMode == 1) begin
            exp = expectedColor(int'(sampX), int'(sampY), sampBlockFlip);
        end else if (!sampBlank && sampMode == 2) begin
            exp = deliveredColor(int'(sampX), int'(sampY));
            if (color == UNDERRUN_COLOR) underruns++;
        end
        if ((sampBlank || sampMode != 0) && color != exp
            && !(sampMode == 2 && !sampBlank && color == UNDERRUN_COLOR)) begin
            $display("CHECK FAILED at %0t: color expected %h got %h (x=%0d y=%0d)",
                     $time, exp, color, sampX, sampY);
            errors++;
        end
    endtask

    task automatic checkProtocol();
        logic [31:0] expAddr;
        expAddr = nextBlockAddr(int'(sampX), int'(sampY), sampFlip);
        if (memReq && !prevReq) begin
            requests++;
            if (prevAck) begin
                $display("memReq rose while memAck was still high at %0t", $time);
                errors++;
            end
            if (memAddr != expAddr) begin
                $display("CHECK FAILED at %0t: memAddr expected %h got %h",
                         $time, expAddr, memAddr);
                errors++;
            end
            if (memCount != 8'd8 || memId != FB_READ_ID) begin
                $display("CHECK FAILED at %0t: memCount/memId expected 08/%h got %h/%h",
                         $time, FB_READ_ID, memCount, memId);
                errors++;
            end
        end
        if (!memReq && prevReq && !prevAck) begin
            $display("memReq fell before memAck rose at %0t", $time);
            errors++;
        end
        prevReq = memReq;
        prevAck = memAck;
    endtask

    always @(negedge clk) begin
        checkColor();
        checkProtocol();
    end

    ////////////////////////////////////////////////////////////
    // Raster stimulus
    ////////////////////////////////////////////////////////////
    task automatic driveStep(input int px, input int py, input logic b);
        @(posedge clk);
        #2;
        x = COORD_W'(px);
        y = COORD_W'(py);
        blank = b;
        // First block of a frame was fetched in the previous frame
        blockFlip = (py == 0 && px < 16) ? lastVisFlip : flip;
    endtask

    task automatic runFrame(input logic [1:0] mode, input logic newFlip, input logic newSlow);
        checkMode = mode;
        for (int line = 0; line < 10; line++) begin
            if (line == 8) begin
                lastVisFlip = flip;
                flip = newFlip;
                slow = newSlow;
            end
            for (int col = 0; col < 48; col++) begin
                driveStep(col, line, line >= 8 || col >= 32);
            end
        end
    endtask

    initial begin
        errors = 0;
        underruns = 0;
        requests = 0;
        resetn = 1'b0;
        x = '0;
        y = '0;
        blank = 1'b1;
        flip = 1'b0;
        slow = 1'b0;
        checkMode = 0;
        blockFlip = 1'b0;
        lastVisFlip = 1'b0;
        sampX = '0;
        sampY = '0;
        sampBlank = 1'b1;
        sampFlip = 1'b0;
        sampBlockFlip = 1'b0;
        sampMode = 0;
        prevReq = 1'b0;
        prevAck = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        resetn = 1'b1;
        runFrame(0, 1'b0, 1'b0);
        runFrame(1, 1'b0, 1'b0);
        runFrame(1, 1'b1, 1'b0);
        runFrame(1, 1'b1, 1'b0);
        runFrame(1, 1'b1, 1'b1);
        runFrame(2, 1'b1, 1'b1);
        runFrame(2, 1'b1, 1'b1);
        @(posedge clk);
        @(negedge clk);
        // Let the last comparison finish
        #1;
        if (underruns == 0) begin
            $display("No underrun colour appeared in slow mode");
            errors++;
        end
        if (requests == 0) begin
            $display("No memory request was seen");
            errors++;
        end
        $display("errors=%0d modelFaults=%0d requests=%0d underruns=%0d",
                 errors, modelFaults, requests, underruns);
        if (errors == 0 && modelFaults == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 6000) begin
            @(posedge clk);
            cycles++;
        end
        $display("Simulation ran past its cycle limit");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/scanFbMemModel.sv */
`default_nettype none

module scanFbMemModel (
    input wire clk,
    input wire resetn,
    input wire memReq,
    input wire [31:0] memAddr,
    input wire slow,
    output logic memAck,
    output logic rdValid,
    output logic [3:0] rdId,
    output logic [31:0] rdData,
    output logic [31:0] setAddr0,
    output logic [31:0] setAddr1,
    output int faults
);
    timeunit 1ns;
    timeprecision 1ps;
    import scanFbPkg::*;

    integer seed;
    logic [31:0] reqAddr;

    // Memory content, a fixed hash of the byte address
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ (addr >> 3) ^ 32'h5a5a_1234;
    endfunction

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    task automatic sendBeat(input logic [3:0] id, input logic [31:0] data);
        @(posedge clk);
        #1;
        rdValid = 1'b1;
        rdId = id;
        rdData = data;
    endtask

    task automatic releaseAck();
        int cnt;
        cnt = 0;
        while (memReq && cnt < 100) begin
            @(posedge clk);
            cnt++;
        end
        if (memReq) begin
            $display("memReq stayed high after memAck at %0t", $time);
            faults++;
        end
        #1;
        memAck = 1'b0;
    endtask

    task automatic sendBurst(input logic [31:0] addr);
        int extra;
        extra = ($random(seed) & 1) + (slow ? 20 : 0);
        waitCycles(extra);
        // Stray beat under a foreign tag
        sendBeat(FB_READ_ID ^ 4'h3, ~memWord(addr));
        for (int i = 0; i < 8; i++) begin
            sendBeat(FB_READ_ID, memWord(addr + 32'(i * 4)));
        end
        if (addr[5]) begin
            setAddr1 = addr;
        end else begin
            setAddr0 = addr;
        end
        @(posedge clk);
        #1;
        rdValid = 1'b0;
    endtask

    initial begin
        seed = 32'h8e5a;
        memAck = 1'b0;
        rdValid = 1'b0;
        rdId = '0;
        rdData = '0;
        setAddr0 = '0;
        setAddr1 = '0;
        faults = 0;
        forever begin
            @(posedge clk);
            if (resetn && memReq && !memAck) begin
                waitCycles($random(seed) & 1);
                #1;
                memAck = 1'b1;
                reqAddr = memAddr;
                fork
                    releaseAck();
                    sendBurst(reqAddr);
                join
            end
        end
    end

endmodule

`default_nettype wire

/* design/scanFbTop.sv */
`default_nettype none

module scanFbTop (
    input wire clk,
    input wire resetn,
    input wire [scanFbPkg::COORD_W-1:0] x,
    input wire [scanFbPkg::COORD_W-1:0] y,
    input wire blank,
    input wire flip,
    input wire memAck,
    input wire rdValid,
    input wire [scanFbPkg::ID_W-1:0] rdId,
    input wire [scanFbPkg::DATA_W-1:0] rdData,
    output logic memReq,
    output logic [scanFbPkg::ADDR_W-1:0] memAddr,
    output logic [scanFbPkg::COUNT_W-1:0] memCount,
    output logic [scanFbPkg::ID_W-1:0] memId,
    output scanFbPkg::rgb8_t color
);

    // Framebuffer of 16 by 4, screen of 32 by 8
    localparam int FB_WIDTH = 16;
    localparam int FB_HEIGHT = 4;
    localparam int BLOCK_WORDS = 8;

    logic fillActive;
    logic fillSet;
    logic fillDone;

    lineReadIf lineRd ();

    fetchSequencer #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .BLOCK_WORDS(BLOCK_WORDS)
    ) fetchSeq_i (
        .clk(clk),
        .resetn(resetn),
        .x(x),
        .y(y),
        .blank(blank),
        .flip(flip),
        .memAck(memAck),
        .fillDone(fillDone),
        .memReq(memReq),
        .memAddr(memAddr),
        .memCount(memCount),
        .memId(memId),
        .fillActive(fillActive),
        .fillSet(fillSet)
    );

    lineBuffer #(
        .FB_WIDTH(FB_WIDTH),
        .BLOCK_WORDS(BLOCK_WORDS)
    ) lineBuf_i (
        .clk(clk),
        .resetn(resetn),
        .x(x),
        .y(y),
        .blank(blank),
        .rdValid(rdValid),
        .rdId(rdId),
        .rdData(rdData),
        .fillActive(fillActive),
        .fillSet(fillSet),
        .fillDone(fillDone),
        .rd(lineRd.source)
    );

    pixelOutput pixOut_i (
        .rd(lineRd.sink),
        .fillActive(fillActive),
        .fillSet(fillSet),
        .color(color)
    );

endmodule

`default_nettype wire

/* design/pixelOutput.sv */
`default_nettype none

module pixelOutput (
    lineReadIf.sink rd,
    input wire fillActive,
    input wire fillSet,
    output scanFbPkg::rgb8_t color
);
    import scanFbPkg::*;

    rgb8_t wordColor;
    logic underrun;

    ////////////////////////////////////////////////////////////
    // RGBX word to colour
    ////////////////////////////////////////////////////////////
    always_comb begin
        wordColor.r = rd.word[31:24];
        wordColor.g = rd.word[23:16];
        wordColor.b = rd.word[15:8];
    end

    // Shown set still being written
    assign underrun = fillActive && (rd.set == fillSet);

    always_comb begin
        if (rd.blank || !rd.valid) begin
            color = '0;
        end else if (underrun) begin
            color = UNDERRUN_COLOR;
        end else begin
            color = wordColor;
        end
    end

endmodule

`default_nettype wire

/* design/lineBuffer.sv */
`default_nettype none

module lineBuffer #(
    parameter int FB_WIDTH = 16,
    parameter int BLOCK_WORDS = 8
) (
    input wire clk,
    input wire resetn,
    input wire [scanFbPkg::COORD_W-1:0] x,
    input wire [scanFbPkg::COORD_W-1:0] y,
    input wire blank,
    input wire rdValid,
    input wire [scanFbPkg::ID_W-1:0] rdId,
    input wire [scanFbPkg::DATA_W-1:0] rdData,
    input wire fillActive,
    input wire fillSet,
    output logic fillDone,
    lineReadIf.source rd
);
    import scanFbPkg::*;

    localparam int IDX_W = bitsFor(BLOCK_WORDS);
    localparam logic [IDX_W-1:0] LAST_BEAT = IDX_W'(BLOCK_WORDS - 1);
    localparam logic [COORD_W-1:0] WIDTH_C = COORD_W'(FB_WIDTH);

    logic [DATA_W-1:0] cache [2][BLOCK_WORDS];
    logic [IDX_W-1:0] beatIdx;
    logic beatHit;
    logic [COORD_W-1:0] fbX;
    logic [ADDR_W-1:0] lookOff;

    ////////////////////////////////////////////////////////////
    // Beat capture
    ////////////////////////////////////////////////////////////
    assign beatHit = fillActive && rdValid && (rdId == FB_READ_ID);

    always_ff @(posedge clk) begin
        if (beatHit) begin
            cache[fillSet][beatIdx] <= rdData;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            beatIdx <= '0;
            fillDone <= 1'b0;
        end else begin
            fillDone <= 1'b0;
            if (beatHit) begin
                beatIdx <= beatIdx + IDX_W'(1);
                if (beatIdx == LAST_BEAT) begin
                    beatIdx <= '0;
                    fillDone <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Word lookup, one cycle
    ////////////////////////////////////////////////////////////
    assign fbX = x >> 1;
    assign lookOff = fbOffset(fbX, y >> 1, FB_WIDTH);

    always_ff @(posedge clk) begin
        rd.word <= cache[lookOff[IDX_W]][lookOff[IDX_W-1:0]];
        rd.set <= lookOff[IDX_W];
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rd.blank <= 1'b1;
            rd.valid <= 1'b0;
        end else begin
            rd.blank <= blank;
            rd.valid <= !blank && (fbX < WIDTH_C);
        end
    end

endmodule

`default_nettype wire

/* design/fetchSequencer.sv */
`default_nettype none

module fetchSequencer #(
    parameter int FB_WIDTH = 16,
    parameter int FB_HEIGHT = 4,
    parameter int BLOCK_WORDS = 8
) (
    input wire clk,
    input wire resetn,
    input wire [scanFbPkg::COORD_W-1:0] x,
    input wire [scanFbPkg::COORD_W-1:0] y,
    input wire blank,
    input wire flip,
    input wire memAck,
    input wire fillDone,
    output logic memReq,
    output logic [scanFbPkg::ADDR_W-1:0] memAddr,
    output logic [scanFbPkg::COUNT_W-1:0] memCount,
    output logic [scanFbPkg::ID_W-1:0] memId,
    output logic fillActive,
    output logic fillSet
);
    import scanFbPkg::*;

    localparam int IDX_W = bitsFor(BLOCK_WORDS);
    localparam logic [COORD_W-1:0] WIDTH_C = COORD_W'(FB_WIDTH);
    localparam logic [COORD_W-1:0] HEIGHT_C = COORD_W'(FB_HEIGHT);
    localparam logic [COORD_W-1:0] STEP_C = COORD_W'(BLOCK_WORDS);

    typedef enum logic [1:0] {
        stIdle,
        stReq,
        stRelease
    } seqState_t;

    seqState_t state;

    logic [COORD_W-1:0] fbX;
    logic [COORD_W-1:0] fbY;
    logic [COORD_W-1:0] nextX;
    logic [COORD_W-1:0] nextY;
    logic [ADDR_W-1:0] curOff;
    logic [ADDR_W-1:0] nextOff;
    logic fetchDue;
    logic launch;

    ////////////////////////////////////////////////////////////
    // Next block address
    ////////////////////////////////////////////////////////////
    assign fbX = x >> 1;
    assign fbY = y >> 1;
    assign curOff = fbOffset(fbX, fbY, FB_WIDTH);

    always_comb begin
        // Start of current block, one block on
        nextX = {fbX[COORD_W-1:IDX_W], {IDX_W{1'b0}}} + STEP_C;
        nextY = fbY;
        if (nextX >= WIDTH_C) begin
            nextX = '0;
            // Even line repeats the row, odd line moves on
            if (y[0]) begin
                nextY = fbY + COORD_W'(1);
                if (nextY >= HEIGHT_C) begin
                    nextY = '0;
                end
            end
        end
        nextOff = fbOffset(nextX, nextY, FB_WIDTH);
    end

    // First even column of a block on a visible position
    assign fetchDue = !blank && (fbX < WIDTH_C) && (fbY < HEIGHT_C) && !x[0]
                      && (curOff[IDX_W-1:0] == '0);

    // Busy sequencer skips the fetch
    assign launch = (state == stIdle) && fetchDue && !fillActive && !memAck;

    ////////////////////////////////////////////////////////////
    // Four-phase handshake and fill tracking
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= stIdle;
            memReq <= 1'b0;
            fillActive <= 1'b0;
            fillSet <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (launch) begin
                        memReq <= 1'b1;
                        fillSet <= nextOff[IDX_W];
                        state <= stReq;
                    end
                end
                stReq: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        fillActive <= 1'b1;
                        state <= stRelease;
                    end
                end
                stRelease: begin
                    // Wait for memory to drop ack
                    if (!memAck) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
            if (fillDone) begin
                fillActive <= 1'b0;
            end
        end
    end

    // Address held stable for the whole request
    always_ff @(posedge clk) begin
        if (launch) begin
            memAddr <= (flip ? FB_BASE1 : FB_BASE0) + (nextOff << 2);
        end
    end

    assign memCount = COUNT_W'(BLOCK_WORDS);
    assign memId = FB_READ_ID;

endmodule

`default_nettype wire

/* design/lineReadIf.sv */
`default_nettype none

interface lineReadIf;
    import scanFbPkg::*;

    logic [DATA_W-1:0] word;
    // Set the word was read from
    logic set;
    logic blank;
    logic valid;

    modport source (
        output word, set, blank, valid
    );

    modport sink (
        input word, set, blank, valid
    );

endinterface

`default_nettype wire

/* design/scanFbPkg.sv */
`default_nettype none

package scanFbPkg;

    ////////////////////////////////////////////////////////////
    // Bus and coordinate widths
    ////////////////////////////////////////////////////////////
    localparam int COORD_W = 12;
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int COUNT_W = 8;
    localparam int ID_W = 4;

    // One output colour
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    ////////////////////////////////////////////////////////////
    // Memory map and tags
    ////////////////////////////////////////////////////////////
    localparam logic [ID_W-1:0] FB_READ_ID = 4'h5;
    localparam logic [ADDR_W-1:0] FB_BASE0 = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] FB_BASE1 = 32'h0002_0000;

    // Magenta marks missing data
    localparam rgb8_t UNDERRUN_COLOR = '{r: 8'hff, g: 8'h00, b: 8'hff};

    // Index width for a count of n, at least one bit
    function automatic int unsigned bitsFor(input int unsigned n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Word offset of a framebuffer pixel
    function automatic logic [ADDR_W-1:0] fbOffset(
        input logic [COORD_W-1:0] fbX,
        input logic [COORD_W-1:0] fbY,
        input int unsigned fbWidth
    );
        return ADDR_W'(fbY) * ADDR_W'(fbWidth) + ADDR_W'(fbX);
    endfunction

endpackage

`default_nettype wire
